/* src.f */
verilog/exec_pkg.sv
verilog/alu.sv
verilog/issue_stage.sv
verilog/exec_stage.sv
verilog/mem_stage.sv
verilog/exec_core.sv
tb/tb_clock.sv
tb/exec_core_chk.sv
tb/exec_core_tb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - verilog/exec_pkg.sv
  - verilog/alu.sv
  - verilog/issue_stage.sv
  - verilog/exec_stage.sv
  - verilog/mem_stage.sv
  - verilog/exec_core.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/exec_core_chk.sv
      - tb/exec_core_tb.sv

/* tb/exec_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb;

    localparam int n_tests  = 24;
    localparam int n_passes = 2;                  // Second pass under back-pressure

    logic                  clk;
    logic                  reset;
    exec_pkg::instr_t      instr;
    logic                  instr_valid;
    logic                  instr_ready;
    exec_pkg::res_t        result;
    logic                  result_valid;
    logic                  result_ready;

    exec_pkg::instr_t      stim [n_tests];
    logic [31:0]           mdl_regs [32];         // Reference register file
    logic [7:0]            mdl_mem [256];         // Reference data memory
    logic [31:0]           lfsr = 32'hcaf0;
    logic                  bp_on = 1'b0;
    int                    received = 0;
    int                    checks = 0;
    int                    errors = 0;
    logic                  rec_ok;

    tb_clock clock_inst (.clk(clk), .reset(reset));

    exec_core exec_core_inst (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    bind exec_core exec_core_chk exec_core_chk_inst (
        .clk(clk), .reset(reset), .instr_ready(instr_ready),
        .result(result), .result_valid(result_valid), .result_ready(result_ready)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic exec_pkg::instr_t mk(input exec_pkg::op_e op, input exec_pkg::funct_e fn,
                                            input int rs, input int rt, input int rd,
                                            input logic [15:0] imm, input int shamt);
        exec_pkg::instr_t t;
        t.op    = op;
        t.funct = fn;
        t.rs    = rs[4:0];
        t.rt    = rt[4:0];
        t.rd    = rd[4:0];
        t.imm   = imm;
        t.shamt = shamt[4:0];
        return t;
    endfunction

    // Executes one instruction on the reference state in program order
    task automatic model_step(input exec_pkg::instr_t in, output exec_pkg::res_t exp,
                              output logic is_load, output logic [31:0] load_exp);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [32:0] wide;                               // Sign extended sum or difference
        logic        ov;
        logic [7:0]  addr;
        logic [7:0]  base;
        logic [4:0]  dst;
        logic        wr;
        a    = mdl_regs[in.rs];
        b    = (in.op == exec_pkg::op_rtype) ? mdl_regs[in.rt] : {{16{in.imm[15]}}, in.imm};
        ov   = 1'b0;
        v    = a + b;
        wide = {a[31], a} + {b[31], b};
        if (in.op == exec_pkg::op_rtype) begin
            case (in.funct)
                exec_pkg::fn_sub: v = a - b;
                exec_pkg::fn_and: v = a & b;
                exec_pkg::fn_or:  v = a | b;
                exec_pkg::fn_xor: v = a ^ b;
                exec_pkg::fn_slt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                exec_pkg::fn_sll: v = b << in.shamt;
                exec_pkg::fn_srl: v = b >> in.shamt;
                default:          v = a + b;
            endcase
            if (in.funct == exec_pkg::fn_sub) begin
                wide = {a[31], a} - {b[31], b};
                ov   = wide[32] != wide[31];             // Outside signed 32-bit range
            end else if (in.funct == exec_pkg::fn_add) begin
                ov = wide[32] != wide[31];
            end
        end else if (in.op == exec_pkg::op_andi) begin
            v = a & b;
        end else if (in.op == exec_pkg::op_ori) begin
            v = a | b;
        end else begin
            ov = wide[32] != wide[31];                   // addi and address add
        end
        addr     = v[7:0];                               // Modulo memory size
        base     = {addr[7:2], 2'b00};
        is_load  = (in.op == exec_pkg::op_lw) || (in.op == exec_pkg::op_lb);
        load_exp = (in.op == exec_pkg::op_lb) ? {24'd0, mdl_mem[addr]} :
                   {mdl_mem[base + 3], mdl_mem[base + 2], mdl_mem[base + 1], mdl_mem[base]};
        if (in.op == exec_pkg::op_sb) begin
            mdl_mem[addr] = mdl_regs[in.rt][7:0];
        end else if (in.op == exec_pkg::op_sw) begin
            for (int k = 0; k < 4; k++) begin
                mdl_mem[base + k] = mdl_regs[in.rt][8*k +: 8];   // Little endian
            end
        end
        dst = (in.op == exec_pkg::op_rtype) ? in.rd : in.rt;
        wr  = (in.op != exec_pkg::op_sw) && (in.op != exec_pkg::op_sb) && (dst != 5'd0);
        if (wr) begin
            mdl_regs[dst] = is_load ? load_exp : v;
        end
        exp.rd       = dst;
        exp.value    = is_load ? load_exp : v;
        exp.regwrite = wr;
        exp.zero     = (v == 32'd0);
        exp.overflow = ov;
    endtask

    task automatic compare_res(input exec_pkg::res_t got, input exec_pkg::res_t exp,
                               input logic load_rec, input int idx);
        logic bad;
        checks++;
        bad = (got.rd !== exp.rd) || (got.regwrite !== exp.regwrite) ||
              (got.zero !== exp.zero) || (got.overflow !== exp.overflow) ||
              (!load_rec && got.value !== exp.value);    // Load data goes to compare_mem
        if (bad) begin
            errors++;
            rec_ok = 1'b0;
            $display("ERR %0t: record %0d got rd=%0d %h %b%b%b, expected rd=%0d %h %b%b%b",
                     $time, idx, got.rd, got.value, got.regwrite, got.zero, got.overflow,
                     exp.rd, exp.value, exp.regwrite, exp.zero, exp.overflow);
        end
    endtask

    task automatic compare_mem(input logic [exec_pkg::reg_size-1:0] got,
                               input logic [exec_pkg::reg_size-1:0] exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            rec_ok = 1'b0;
            $display("ERR %0t: load %0d got %h, memory image holds %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_record(input exec_pkg::res_t got);
        exec_pkg::res_t   exp;
        logic             is_load;
        logic [31:0]      load_exp;
        int               idx;
        idx    = received % n_tests;
        rec_ok = 1'b1;
        if (received >= n_tests * n_passes) begin
            errors++;
            $display("Unexpected extra result record at time %0t", $time);
        end else begin
            model_step(stim[idx], exp, is_load, load_exp);
            compare_res(got, exp, is_load, idx);
            if (is_load) begin
                compare_mem(got.value, load_exp, idx);
            end
            $display("test %0d pass %0d: %s", idx, received / n_tests, rec_ok ? "ok" : "MISMATCH");
        end
        received++;
    endtask

    task automatic drive_table;
        for (int i = 0; i < n_tests; i++) begin
            instr       <= stim[i];
            instr_valid <= 1'b1;
            @(posedge clk);
            while (!instr_ready) @(posedge clk);   // Hold until accepted
        end
        instr_valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (bp_on) begin
            lfsr = lfsr_step(lfsr);
            result_ready <= lfsr[0];               // One LFSR step per bit
        end else begin
            result_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!reset && result_valid && result_ready) begin
            check_record(result);
        end
    end

    initial begin
        repeat (20 * n_tests * n_passes + 100) @(posedge clk);
        $display("Run timed out before all result records arrived");
        $display("tests failed");
        $finish;
    end

    initial begin
        instr        = '0;
        instr_valid  = 1'b0;
        result_ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mdl_regs[i] = 32'd0;                   // Matches register file reset
        end
        stim[0]  = mk(exec_pkg::op_addi,  exec_pkg::fn_add, 0, 1, 0, 16'h7fff, 0);
        stim[1]  = mk(exec_pkg::op_rtype, exec_pkg::fn_sll, 0, 1, 2, 16'h0, 16);
        stim[2]  = mk(exec_pkg::op_rtype, exec_pkg::fn_add, 2, 2, 3, 16'h0, 0);  // Overflow
        stim[3]  = mk(exec_pkg::op_rtype, exec_pkg::fn_sub, 1, 1, 4, 16'h0, 0);  // Zero
        stim[4]  = mk(exec_pkg::op_addi,  exec_pkg::fn_add, 0, 5, 0, 16'hfffb, 0);
        stim[5]  = mk(exec_pkg::op_rtype, exec_pkg::fn_slt, 5, 1, 6, 16'h0, 0);
        stim[6]  = mk(exec_pkg::op_rtype, exec_pkg::fn_and, 1, 5, 7, 16'h0, 0);
        stim[7]  = mk(exec_pkg::op_rtype, exec_pkg::fn_or,  2, 1, 8, 16'h0, 0);
        stim[8]  = mk(exec_pkg::op_rtype, exec_pkg::fn_xor, 8, 1, 9, 16'h0, 0);
        stim[9]  = mk(exec_pkg::op_rtype, exec_pkg::fn_srl, 0, 8, 10, 16'h0, 4);
        stim[10] = mk(exec_pkg::op_andi,  exec_pkg::fn_add, 8, 11, 0, 16'h00ff, 0);
        stim[11] = mk(exec_pkg::op_ori,   exec_pkg::fn_add, 0, 12, 0, 16'h1234, 0);
        stim[12] = mk(exec_pkg::op_addi,  exec_pkg::fn_add, 1, 0, 0, 16'h0001, 0); // r0 dest
        stim[13] = mk(exec_pkg::op_rtype, exec_pkg::fn_add, 0, 12, 13, 16'h0, 0);
        stim[14] = mk(exec_pkg::op_sw,    exec_pkg::fn_add, 0, 8, 0, 16'h0010, 0);
        stim[15] = mk(exec_pkg::op_lw,    exec_pkg::fn_add, 0, 14, 0, 16'h0010, 0);
        stim[16] = mk(exec_pkg::op_rtype, exec_pkg::fn_add, 14, 1, 15, 16'h0, 0); // Load use
        stim[17] = mk(exec_pkg::op_sw,    exec_pkg::fn_add, 0, 9, 0, 16'h0020, 0);
        stim[18] = mk(exec_pkg::op_sb,    exec_pkg::fn_add, 0, 12, 0, 16'h0021, 0);
        stim[19] = mk(exec_pkg::op_lb,    exec_pkg::fn_add, 0, 16, 0, 16'h0021, 0);
        stim[20] = mk(exec_pkg::op_sb,    exec_pkg::fn_add, 0, 16, 0, 16'h0022, 0); // Load store
        stim[21] = mk(exec_pkg::op_lw,    exec_pkg::fn_add, 0, 17, 0, 16'h0023, 0);
        stim[22] = mk(exec_pkg::op_lb,    exec_pkg::fn_add, 5, 18, 0, 16'h0026, 0);
        stim[23] = mk(exec_pkg::op_rtype, exec_pkg::fn_sub, 17, 18, 19, 16'h0, 0);
        @(posedge clk);
        while (reset) @(posedge clk);
        drive_table();
        wait (received == n_tests);
        @(posedge clk);
        bp_on <= 1'b1;                             // Random result_ready from here on
        drive_table();
        wait (received == n_tests * n_passes);
        repeat (10) @(posedge clk);                // Catch duplicated records
        $display("%0d records, %0d checks, %0d errors, %0d assertion failures",
                 received, checks, errors, exec_core_inst.exec_core_chk_inst.fail_count);
        if (errors == 0 && received == n_tests * n_passes &&
            exec_core_inst.exec_core_chk_inst.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/exec_core_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core_chk (
    input wire                 clk,
    input wire                 reset,
    input wire                 instr_ready,
    input wire exec_pkg::res_t result,
    input wire                 result_valid,
    input wire                 result_ready
);

    int fail_count = 0;                            // Failed assertions so far

    // Output record held under back-pressure
    result_stable: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else begin
            $error("result changed while stalled by result_ready");
            fail_count++;
        end

    ready_in_reset: assert property (@(posedge clk) reset |-> !instr_ready)
        else begin
            $error("instr_ready high during reset");
            fail_count++;
        end

    // Valid cleared by the first reset edge
    no_valid_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !result_valid)
        else begin
            $error("result_valid high during reset");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);                 // Held 4 cycles
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* verilog/exec_core.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core (
    input  wire                   clk,
    input  wire                   reset,
    input  wire exec_pkg::instr_t instr,
    input  wire                   instr_valid,
    output logic                  instr_ready,
    output exec_pkg::res_t        result,
    output logic                  result_valid,
    input  wire                   result_ready
);

    exec_pkg::issue_t iss;
    exec_pkg::exe_t   exe;
    logic             advance;                     // All stage registers load
    logic             stall;                       // Load-use hazard
    logic             wb_we;                       // Commit on output handshake

    assign advance     = result_ready || !result_valid;
    assign instr_ready = advance && !stall && !reset;
    assign wb_we       = result_valid && result_ready && result.regwrite;

    issue_stage issue_inst (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .wb_we        (wb_we),
        .wb_rd        (result.rd),
        .wb_data      (result.value),
        .exe_rd       (exe.rd),                    // Producer about to leave execute
        .exe_regwrite (exe.regwrite),
        .stall        (stall),
        .iss          (iss)
    );

    exec_stage exec_inst (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .iss     (iss),
        .wb_fwd  (result.value),                   // Output register value
        .exe     (exe)
    );

    mem_stage mem_inst (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .exe          (exe),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 advance,
    input  wire exec_pkg::exe_t exe,
    output exec_pkg::res_t      result,
    output logic                result_valid
);

    localparam int wsel = exec_pkg::dmem_addr - 2;      // Word index width

    logic [7:0]                     dmem [exec_pkg::dmem_bytes];
    logic [exec_pkg::dmem_addr-1:0] addr;               // Address modulo memory size
    logic [wsel-1:0]                word;               // Low two bits dropped
    logic [exec_pkg::reg_size-1:0]  load_word;
    logic [exec_pkg::reg_size-1:0]  load_byte;
    logic [exec_pkg::reg_size-1:0]  load_data;
    logic                           do_store;

    assign addr = exe.alu_result[exec_pkg::dmem_addr-1:0];
    assign word = addr[exec_pkg::dmem_addr-1:2];

    // Little endian, lowest address is bits 7:0
    assign load_word = {dmem[{word, 2'd3}], dmem[{word, 2'd2}],
                        dmem[{word, 2'd1}], dmem[{word, 2'd0}]};
    assign load_byte = {{(exec_pkg::reg_size-8){1'b0}}, dmem[addr]};   // Zero extend
    assign load_data = exe.is_byte ? load_byte : load_word;

    assign do_store = advance && exe.valid && exe.mem_write;   // Only on advancing edge

    always_ff @(posedge clk) begin
        if (do_store) begin
            if (exe.is_byte) begin
                dmem[addr] <= exe.store_data[7:0];
            end else begin
                dmem[{word, 2'd0}] <= exe.store_data[7:0];
                dmem[{word, 2'd1}] <= exe.store_data[15:8];
                dmem[{word, 2'd2}] <= exe.store_data[23:16];
                dmem[{word, 2'd3}] <= exe.store_data[31:24];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid    <= 1'b0;
            result.regwrite <= 1'b0;
        end else if (advance) begin
            result_valid    <= exe.valid;
            result.rd       <= exe.rd;
            result.value    <= exe.mem_read ? load_data : exe.alu_result;  // Writeback select
            result.regwrite <= exe.regwrite;
            result.zero     <= exe.zero;
            result.overflow <= exe.overflow;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            advance,
    input  wire exec_pkg::issue_t          iss,
    input  wire [exec_pkg::reg_size-1:0]   wb_fwd,        // Output register value
    output exec_pkg::exe_t                 exe
);

    logic [exec_pkg::reg_size-1:0] mem_fwd;        // Result held in exe register
    logic [exec_pkg::reg_size-1:0] operand1;
    logic [exec_pkg::reg_size-1:0] rt_fwd;         // Forwarded rt, also store data
    logic [exec_pkg::reg_size-1:0] operand2;
    logic [exec_pkg::reg_size-1:0] alu_out;
    logic                          alu_zero;
    logic                          alu_overflow;

    assign mem_fwd = exe.alu_result;

    always_comb begin
        case (iss.fwd1)
            exec_pkg::fwd_mem: operand1 = mem_fwd;
            exec_pkg::fwd_wb:  operand1 = wb_fwd;
            default:           operand1 = iss.rs_data;
        endcase
    end

    always_comb begin
        case (iss.fwd2)
            exec_pkg::fwd_mem: rt_fwd = mem_fwd;
            exec_pkg::fwd_wb:  rt_fwd = wb_fwd;
            default:           rt_fwd = iss.rt_data;
        endcase
    end

    assign operand2 = iss.use_imm ? iss.imm : rt_fwd;   // Immediate select

    alu alu_inst (
        .aluop    (iss.aluop),
        .src1     (operand1),
        .src2     (operand2),
        .shamt    (iss.shamt),
        .out      (alu_out),
        .zero     (alu_zero),
        .overflow (alu_overflow)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            exe.valid     <= 1'b0;
            exe.regwrite  <= 1'b0;
            exe.mem_read  <= 1'b0;
            exe.mem_write <= 1'b0;
        end else if (advance) begin
            exe.valid      <= iss.valid;
            exe.alu_result <= alu_out;
            exe.store_data <= rt_fwd;
            exe.zero       <= alu_zero;
            exe.overflow   <= alu_overflow;
            exe.rd         <= iss.rd;
            exe.regwrite   <= iss.regwrite;             // Low for bubbles
            exe.mem_read   <= iss.mem_read;
            exe.mem_write  <= iss.mem_write;
            exe.is_byte    <= iss.is_byte;
        end
    end

endmodule

`default_nettype wire

/* verilog/issue_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             advance,       // Pipeline moves this edge
    input  wire exec_pkg::instr_t           instr,
    input  wire                             instr_valid,
    input  wire                             wb_we,         // Accepted result commit
    input  wire [exec_pkg::reg_addr-1:0]    wb_rd,
    input  wire [exec_pkg::reg_size-1:0]    wb_data,
    input  wire [exec_pkg::reg_addr-1:0]    exe_rd,        // Execute register dest
    input  wire                             exe_regwrite,
    output logic                            stall,
    output exec_pkg::issue_t                iss
);

    logic [exec_pkg::reg_size-1:0] regs [2**exec_pkg::reg_addr];
    logic [exec_pkg::reg_size-1:0] rs_val;
    logic [exec_pkg::reg_size-1:0] rt_val;
    logic [exec_pkg::reg_addr-1:0] dest;
    logic                          uses_rt;        // rt is a source operand
    logic                          iss_load;       // Load sitting in issue register
    logic                          take;           // Accept incoming instruction
    exec_pkg::issue_t              iss_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**exec_pkg::reg_addr; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;                // r0 never written
        end
    end

    // Write-through so a same-cycle commit is seen
    assign rs_val = (instr.rs == '0) ? '0 :
                    (wb_we && wb_rd == instr.rs) ? wb_data : regs[instr.rs];
    assign rt_val = (instr.rt == '0) ? '0 :
                    (wb_we && wb_rd == instr.rt) ? wb_data : regs[instr.rt];

    assign uses_rt  = (instr.op == exec_pkg::op_rtype) ||
                      (instr.op == exec_pkg::op_sw) || (instr.op == exec_pkg::op_sb);
    assign iss_load = iss.valid && iss.mem_read && iss.regwrite;
    assign stall    = instr_valid && iss_load &&
                      ((instr.rs == iss.rd) || (uses_rt && instr.rt == iss.rd));
    assign take     = instr_valid && !stall;

    always_comb begin
        iss_next          = '0;
        iss_next.valid    = 1'b1;
        iss_next.op       = instr.op;
        iss_next.aluop    = exec_pkg::alu_add;     // Address calc and addi
        iss_next.rs_data  = rs_val;
        iss_next.rt_data  = rt_val;
        iss_next.imm      = {{(exec_pkg::reg_size-16){instr.imm[15]}}, instr.imm};
        iss_next.shamt    = instr.shamt;
        iss_next.use_imm  = 1'b1;
        iss_next.regwrite = 1'b1;
        dest              = instr.rt;              // I-type target
        case (instr.op)
            exec_pkg::op_rtype: begin
                iss_next.use_imm = 1'b0;
                dest             = instr.rd;
                case (instr.funct)
                    exec_pkg::fn_add: iss_next.aluop = exec_pkg::alu_add;
                    exec_pkg::fn_sub: iss_next.aluop = exec_pkg::alu_sub;
                    exec_pkg::fn_and: iss_next.aluop = exec_pkg::alu_and;
                    exec_pkg::fn_or:  iss_next.aluop = exec_pkg::alu_or;
                    exec_pkg::fn_xor: iss_next.aluop = exec_pkg::alu_xor;
                    exec_pkg::fn_slt: iss_next.aluop = exec_pkg::alu_slt;
                    exec_pkg::fn_sll: iss_next.aluop = exec_pkg::alu_sll;
                    default:          iss_next.aluop = exec_pkg::alu_srl;
                endcase
            end
            exec_pkg::op_andi: iss_next.aluop = exec_pkg::alu_and;
            exec_pkg::op_ori:  iss_next.aluop = exec_pkg::alu_or;
            exec_pkg::op_lw:   iss_next.mem_read = 1'b1;
            exec_pkg::op_lb: begin
                iss_next.mem_read = 1'b1;
                iss_next.is_byte  = 1'b1;
            end
            exec_pkg::op_sw:   iss_next.regwrite = 1'b0;     // Stores write nothing
            exec_pkg::op_sb: begin
                iss_next.regwrite = 1'b0;
                iss_next.is_byte  = 1'b1;
            end
            default: ;                                       // addi
        endcase
        iss_next.mem_write = (instr.op == exec_pkg::op_sw) || (instr.op == exec_pkg::op_sb);
        iss_next.rd        = dest;
        if (dest == '0) begin
            iss_next.regwrite = 1'b0;              // Drop r0 writes early
        end
        // Younger producer first, loads never forward from here
        iss_next.fwd1 = exec_pkg::fwd_reg;
        if (iss.regwrite && !iss.mem_read && iss.rd == instr.rs) begin
            iss_next.fwd1 = exec_pkg::fwd_mem;
        end else if (exe_regwrite && exe_rd == instr.rs) begin
            iss_next.fwd1 = exec_pkg::fwd_wb;
        end
        iss_next.fwd2 = exec_pkg::fwd_reg;
        if (iss.regwrite && !iss.mem_read && iss.rd == instr.rt) begin
            iss_next.fwd2 = exec_pkg::fwd_mem;
        end else if (exe_regwrite && exe_rd == instr.rt) begin
            iss_next.fwd2 = exec_pkg::fwd_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || (advance && !take)) begin     // Reset or bubble
            iss.valid     <= 1'b0;
            iss.regwrite  <= 1'b0;
            iss.mem_read  <= 1'b0;
            iss.mem_write <= 1'b0;
        end else if (advance) begin
            iss <= iss_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire exec_pkg::aluop_e          aluop,
    input  wire [exec_pkg::reg_size-1:0]   src1,
    input  wire [exec_pkg::reg_size-1:0]   src2,     // Register or immediate
    input  wire [4:0]                      shamt,
    output logic [exec_pkg::reg_size-1:0]  out,
    output logic                           zero,
    output logic                           overflow
);

    localparam int msb = exec_pkg::reg_size - 1;

    logic [exec_pkg::reg_size-1:0] sum;            // src1 + src2
    logic [exec_pkg::reg_size-1:0] diff;           // src1 - src2
    logic                          add_ovf;
    logic                          sub_ovf;
    logic                          less;           // Signed compare

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // Same input signs, result sign flipped
    assign add_ovf = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
    // Opposite input signs, result follows subtrahend
    assign sub_ovf = (src1[msb] != src2[msb]) && (diff[msb] != src1[msb]);
    assign less    = $signed(src1) < $signed(src2);

    always_comb begin
        out      = sum;                             // Default add
        overflow = 1'b0;
        case (aluop)
            exec_pkg::alu_add: begin
                out      = sum;
                overflow = add_ovf;
            end
            exec_pkg::alu_sub: begin
                out      = diff;
                overflow = sub_ovf;
            end
            exec_pkg::alu_and: out = src1 & src2;
            exec_pkg::alu_or:  out = src1 | src2;
            exec_pkg::alu_xor: out = src1 ^ src2;
            exec_pkg::alu_slt: out = {{(exec_pkg::reg_size-1){1'b0}}, less};
            exec_pkg::alu_sll: out = src2 << shamt;        // Shift rt operand
            exec_pkg::alu_srl: out = src2 >> shamt;        // Logical, zero fill
            default: begin
                out      = sum;
                overflow = 1'b0;
            end
        endcase
    end

    assign zero = (out == '0);

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int reg_size   = 32;               // Data word width
    localparam int reg_addr   = 5;                // Register index width
    localparam int dmem_bytes = 256;              // Data memory size
    localparam int dmem_addr  = 8;                // Byte address width

    typedef enum logic [2:0] {
        op_rtype, op_addi, op_andi, op_ori,       // ALU classes
        op_lw, op_sw, op_lb, op_sb                // Memory classes
    } op_e;

    typedef enum logic [2:0] {
        fn_add, fn_sub, fn_and, fn_or,
        fn_xor, fn_slt, fn_sll, fn_srl
    } funct_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_sll, alu_srl
    } aluop_e;

    typedef enum logic [1:0] {
        fwd_reg,                                  // Register file value
        fwd_mem,                                  // Execute register result
        fwd_wb                                    // Output register value
    } fwd_sel_e;

    typedef struct packed {
        op_e                 op;
        funct_e              funct;               // R-type only
        logic [reg_addr-1:0] rs;
        logic [reg_addr-1:0] rt;
        logic [reg_addr-1:0] rd;
        logic [15:0]         imm;
        logic [4:0]          shamt;
    } instr_t;

    typedef struct packed {
        logic                valid;
        op_e                 op;
        aluop_e              aluop;
        logic [reg_size-1:0] rs_data;
        logic [reg_size-1:0] rt_data;
        logic [reg_size-1:0] imm;                 // Sign extended
        logic [4:0]          shamt;
        fwd_sel_e            fwd1;
        fwd_sel_e            fwd2;
        logic                use_imm;
        logic [reg_addr-1:0] rd;                  // Resolved destination
        logic                regwrite;
        logic                mem_read;
        logic                mem_write;
        logic                is_byte;
    } issue_t;

    typedef struct packed {
        logic                valid;
        logic [reg_size-1:0] alu_result;
        logic [reg_size-1:0] store_data;
        logic                zero;
        logic                overflow;
        logic [reg_addr-1:0] rd;
        logic                regwrite;
        logic                mem_read;
        logic                mem_write;
        logic                is_byte;
    } exe_t;

    typedef struct packed {
        logic [reg_addr-1:0] rd;
        logic [reg_size-1:0] value;
        logic                regwrite;
        logic                zero;
        logic                overflow;
    } res_t;

endpackage

`default_nettype wire
